// ==== testbench/spr_input.txt ====
# test mt mf sprn bl dec hold data exc refetch rnd expRd expRet expLink expCtr eq1 eq2 evpr
# exc = {swap01,swap23,swapEnable,wbRfci}; rnd 1 writes a random word, 2 expects it back
1 0 1 008 0 0 0 5a5a5a5a 0 00000000 0 00000000 00000000 00000000 ffffffff 0 0 0000
1 0 1 009 0 0 0 5a5a5a5a 0 00000000 0 ffffffff 00000000 00000000 ffffffff 0 0 0000
1 0 1 117 0 0 0 5a5a5a5a 0 00000000 0 00000000 00000000 00000000 ffffffff 0 0 0000
1 0 1 3d6 0 0 0 5a5a5a5a 0 00000000 0 00000000 00000000 00000000 ffffffff 0 0 0000
2 1 0 110 0 0 0 11111111 0 00000000 0 11111111 00000000 00000000 ffffffff 0 0 0000
2 0 1 110 0 0 0 5a5a5a5a 0 00000000 0 11111111 00000000 00000000 ffffffff 0 0 0000
2 1 0 113 0 0 0 00000000 0 00000000 1 00000000 00000000 00000000 ffffffff 0 0 0000
2 0 1 113 0 0 0 5a5a5a5a 0 00000000 2 00000000 00000000 00000000 ffffffff 0 0 0000
2 1 0 115 0 0 0 55aa55aa 0 00000000 0 55aa55aa 00000000 00000000 ffffffff 0 0 0000
2 1 0 105 0 0 0 deadbeef 0 00000000 0 deadbeef 00000000 00000000 ffffffff 0 0 0000
2 0 1 105 0 0 0 5a5a5a5a 0 00000000 0 55aa55aa 00000000 00000000 ffffffff 0 0 0000
2 1 0 008 0 0 0 12345678 0 00000000 0 12345678 00000000 12345678 ffffffff 0 0 0000
2 0 1 008 0 0 0 5a5a5a5a 0 00000000 0 12345678 00000000 12345678 ffffffff 0 0 0000
2 1 0 3d6 0 0 0 abcd1234 0 00000000 0 abcd1234 00000000 12345678 ffffffff 0 0 abcd
2 0 1 3d6 0 0 0 5a5a5a5a 0 00000000 0 abcd0000 00000000 12345678 ffffffff 0 0 abcd
2 1 0 01a 0 0 0 87654323 0 00000000 0 87654323 00000000 12345678 ffffffff 0 0 abcd
2 0 1 01a 0 0 0 5a5a5a5a 0 00000000 0 87654320 21d950c8 12345678 ffffffff 0 0 abcd
2 1 0 3de 0 0 0 fedcba99 0 00000000 0 fedcba99 21d950c8 12345678 ffffffff 0 0 abcd
2 0 1 3de 0 0 0 5a5a5a5a 0 00000000 0 fedcba98 3fb72ea6 12345678 ffffffff 0 0 abcd
2 0 1 000 0 0 0 5a5a5a5a 0 00000000 0 2468ace0 21d950c8 12345678 ffffffff 0 0 abcd
3 0 0 000 1 0 0 8000000c 0 00000000 0 8000000c 21d950c8 80000010 ffffffff 0 0 abcd
3 0 1 008 0 0 0 5a5a5a5a 0 00000000 0 80000010 21d950c8 80000010 ffffffff 0 0 abcd
4 1 0 009 0 0 0 00000003 0 00000000 0 00000003 21d950c8 80000010 00000003 0 0 abcd
4 0 0 000 0 1 0 00000000 0 00000000 0 00000000 21d950c8 80000010 00000002 0 1 abcd
4 0 0 000 0 1 0 00000000 0 00000000 0 00000000 21d950c8 80000010 00000001 1 0 abcd
4 0 0 000 0 1 0 00000000 0 00000000 0 00000000 21d950c8 80000010 00000000 0 0 abcd
4 0 1 009 0 0 0 5a5a5a5a 0 00000000 0 00000000 21d950c8 80000010 00000000 0 0 abcd
5 1 0 008 0 0 1 11223344 0 00000000 0 11223344 21d950c8 80000010 00000000 0 0 abcd
5 1 0 009 0 1 1 00000007 0 00000000 0 00000007 21d950c8 80000010 00000000 0 0 abcd
5 0 0 000 0 0 1 00000000 a 0aaaaaaa 0 00000000 21d950c8 80000010 00000000 0 0 abcd
5 0 1 01a 0 0 0 5a5a5a5a 0 00000000 0 2aaaaaa8 0aaaaaaa 80000010 00000000 0 0 abcd
5 0 0 000 0 0 1 00000000 6 15555555 0 00000000 0aaaaaaa 80000010 00000000 0 0 abcd
5 0 0 000 0 0 0 00000000 1 00000000 0 00000000 15555555 80000010 00000000 0 0 abcd
5 0 1 008 0 0 0 5a5a5a5a 0 00000000 0 80000010 0aaaaaaa 80000010 00000000 0 0 abcd

// ==== all.f ====
+incdir+hdl
hdl/sprPkg.sv
hdl/sprDecode.sv
hdl/branchRegs.sv
hdl/generalSprs.sv
hdl/exceptionRegs.sv
hdl/sprReadMux.sv
hdl/sprUnit.sv
testbench/sprUnit_checker.sv
testbench/sprUnitTb.sv

// ==== testbench/sprUnitTb.sv ====
/*
 * SPR unit testbench
 * vectors from a data file, driven on the falling edge; checks
 * the comb outputs before the edge, the registers after it
 */
`timescale 1ns/1ps
`include "spr_macros.svh"

module sprUnitTb;

  localparam int ResetCycles = 5;
  localparam int MaxVectors  = 64;
  localparam logic [`SPR_WIDTH-1:0] CrValue = 32'h2468_ACE0;

  // one vector, stimulus first, then expected values
  typedef struct packed {
    logic [3:0]                 testId;
    logic                       mt;
    logic                       mf;
    logic [`SPRN_WIDTH-1:0]     sprn;
    logic                       bl;
    logic                       dec;
    logic                       hold;
    logic [`SPR_WIDTH-1:0]      data;
    logic [3:0]                 exc;
    logic [`SPR_ADDR_WIDTH-1:0] refetch;
    logic [1:0]                 rnd;
    logic [`SPR_WIDTH-1:0]      expRd;
    logic [`SPR_ADDR_WIDTH-1:0] expRet;
    logic [`SPR_WIDTH-1:0]      expLink;
    logic [`SPR_WIDTH-1:0]      expCtr;
    logic                       expEq1;
    logic                       expEq2;
    logic [`EVPR_WIDTH-1:0]     expEvpr;
  } vecT;

  logic                       CB;
  logic                       rstN;
  sprPkg::exeOpT              exeOp;
  sprPkg::exceptT             exception;
  logic                       sprHold;
  logic [`SPR_ADDR_WIDTH-1:0] refetchAddr;
  logic [`SPR_WIDTH-1:0]      crIn;
  sprPkg::sprWordU            readData;
  logic [`SPR_WIDTH-1:0]      link;
  logic [`SPR_WIDTH-1:0]      ctr;
  logic                       ctrEq1;
  logic                       ctrEq2;
  logic [`EVPR_WIDTH-1:0]     evpr;
  logic [`SPR_ADDR_WIDTH-1:0] returnAddr;
  logic                       exeMtLr;
  logic                       exeMtCtr;

  vecT         vecs[$];
  logic [31:0] rndVal;
  int          errCount    = 0;
  int          testErrs    = 0;
  int          testsPassed = 0;
  int          testsFailed = 0;
  int          cycles      = 0;
  int          cycleLimit  = ResetCycles + MaxVectors * 4;
  logic [3:0]  curTest;

  sprUnit sprUnit_i (
    .CB(CB), .rstN(rstN), .exeOp(exeOp), .exception(exception), .sprHold(sprHold),
    .refetchAddr(refetchAddr), .crIn(crIn), .readData(readData), .link(link),
    .ctr(ctr), .ctrEq1(ctrEq1), .ctrEq2(ctrEq2), .evpr(evpr),
    .returnAddr(returnAddr), .exeMtLr(exeMtLr), .exeMtCtr(exeMtCtr)
  );

  bind sprUnit sprUnitChecker sprUnitChecker_i (
    .CB(CB), .rstN(rstN), .exeOp(exeOp), .sprHold(sprHold), .readData(readData),
    .link(link), .ctr(ctr), .ctrEq1(ctrEq1), .ctrEq2(ctrEq2)
  );

  // 100 ns period
  always begin
    CB = 1'b0;
    #50;
    CB = 1'b1;
    #50;
  end

  always @(posedge CB) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("timeout, run still going after %0d cycles", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  //********************************************************************
  // helpers
  //********************************************************************

  task automatic loadVectors();
    int          fd;
    int          n;
    int          lineNo;
    string       line;
    logic [31:0] col [0:17];
    fd = $fopen("testbench/spr_input.txt", "r");
    lineNo = 0;
    if (fd == 0) begin
      $display("cannot open the vector file testbench/spr_input.txt");
      errCount++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        lineNo++;
        // skip blank and comment lines
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                    col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                    col[15], col[16], col[17]);
        if (n != 18) begin
          $display("vector file line %0d is malformed", lineNo);
          errCount++;
        end else begin
          vecs.push_back({col[0][3:0], col[1][0], col[2][0], col[3][9:0], col[4][0],
                          col[5][0], col[6][0], col[7], col[8][3:0], col[9][29:0],
                          col[10][1:0], col[11], col[12][29:0], col[13], col[14],
                          col[15][0], col[16][0], col[17][15:0]});
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic checkWord(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
      errCount++;
      testErrs++;
    end
  endtask

  function automatic string testName(input logic [3:0] id);
    case (id)
      4'd1:    return "reset values";
      4'd2:    return "mtspr/mfspr readback";
      4'd3:    return "branch-and-link";
      4'd4:    return "ctr decrement flags";
      4'd5:    return "hold and interrupt swap";
      default: return "unnamed";
    endcase
  endfunction

  task automatic reportTest(input logic [3:0] id);
    if (testErrs == 0) begin
      $display("test %0d (%s): passed", id, testName(id));
      testsPassed++;
    end else begin
      $display("test %0d (%s): failed, %0d errors", id, testName(id), testErrs);
      testsFailed++;
    end
    testErrs = 0;
  endtask

  // called on a falling edge, returns on the next one
  task automatic runVector(input vecT v);
    logic [31:0] dataVal;
    logic [31:0] expRd;
    logic        expMtLr;
    logic        expMtCtr;
    if (v.rnd == 2'd1) begin
      rndVal = $urandom;
    end
    dataVal = (v.rnd == 2'd1) ? rndVal : v.data;
    // marked vectors write or read back the random word
    expRd = (v.rnd != 2'd0) ? rndVal : v.expRd;
    // move-to flags follow the op itself, hold or not
    expMtLr  = v.mt && (v.sprn == `SPRN_LR);
    expMtCtr = v.mt && (v.sprn == `SPRN_CTR);
    exeOp.mtspr = v.mt;
    exeOp.mfspr = v.mf;
    // instruction field holds the two halves swapped
    exeOp.sprf = {v.sprn[4:0], v.sprn[9:5]};
    exeOp.branchAndLink = v.bl;
    exeOp.bcDecr = v.dec;
    exeOp.data.data = dataVal;
    exception = sprPkg::exceptT'(v.exc);
    sprHold = v.hold;
    refetchAddr = v.refetch;
    // comb outputs, well before the rising edge
    #25;
    checkWord("readData", readData.data, expRd);
    checkWord("returnAddr", {2'b00, returnAddr}, {2'b00, v.expRet});
    checkWord("exeMtLr", {31'd0, exeMtLr}, {31'd0, expMtLr});
    checkWord("exeMtCtr", {31'd0, exeMtCtr}, {31'd0, expMtCtr});
    @(posedge CB);
    @(negedge CB);
    checkWord("link", link, v.expLink);
    checkWord("ctr", ctr, v.expCtr);
    checkWord("ctrEq1", {31'd0, ctrEq1}, {31'd0, v.expEq1});
    checkWord("ctrEq2", {31'd0, ctrEq2}, {31'd0, v.expEq2});
    checkWord("evpr", {16'd0, evpr}, {16'd0, v.expEvpr});
  endtask

  //********************************************************************
  // main sequence
  //********************************************************************

  initial begin
    // seeds the generator for the whole run
    rndVal = $urandom(6860);
    rstN = 1'b0;
    exeOp = '0;
    exception = '0;
    sprHold = 1'b0;
    refetchAddr = '0;
    crIn = CrValue;
    loadVectors();
    if (vecs.size() == 0) begin
      $display("no vectors were loaded");
      errCount++;
    end
    cycleLimit = ResetCycles + vecs.size() * 4;
    repeat (ResetCycles) @(posedge CB);
    @(negedge CB);
    rstN = 1'b1;
    if (vecs.size() > 0) begin
      curTest = vecs[0].testId;
      foreach (vecs[i]) begin
        if (vecs[i].testId != curTest) begin
          reportTest(curTest);
          curTest = vecs[i].testId;
        end
        runVector(vecs[i]);
      end
      reportTest(curTest);
    end
    // add the bound checker's failures
    errCount += sprUnit_i.sprUnitChecker_i.failCount;
    $display("%0d tests passed, %0d failed, %0d errors", testsPassed, testsFailed,
             errCount);
    if (errCount == 0 && testsFailed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== testbench/sprUnit_checker.sv ====
/*
 * SPR unit assertion checker
 * bound into the top level, watches the CTR flags, the read bypass
 * and LR under hold
 */
`timescale 1ns/1ps
`include "spr_macros.svh"

module sprUnitChecker (
  input logic                  CB,
  input logic                  rstN,
  input sprPkg::exeOpT         exeOp,
  input logic                  sprHold,
  input sprPkg::sprWordU       readData,
  input logic [`SPR_WIDTH-1:0] link,
  input logic [`SPR_WIDTH-1:0] ctr,
  input logic                  ctrEq1,
  input logic                  ctrEq2
);

  // count of failed assertions
  int failCount = 0;

  // flag is registered together with the value it describes
  eq1MeansOne: assert property (@(posedge CB) disable iff (!rstN)
    ctrEq1 |-> (ctr == `SPR_WIDTH'd1))
    else begin
      $error("ctrEq1 high while ctr is %h", ctr);
      failCount++;
    end

  eqOneHot: assert property (@(posedge CB) disable iff (!rstN)
    !(ctrEq1 && ctrEq2))
    else begin
      $error("ctrEq1 and ctrEq2 both high");
      failCount++;
    end

  // no mfspr, the read bus mirrors the write bus
  readBypass: assert property (@(posedge CB) disable iff (!rstN)
    !exeOp.mfspr |-> (readData.data == exeOp.data.data))
    else begin
      $error("readData differs from write data without mfspr");
      failCount++;
    end

  lrHeld: assert property (@(posedge CB) disable iff (!rstN)
    (sprHold && !exeOp.branchAndLink) |=> $stable(link))
    else begin
      $error("link changed across a held edge");
      failCount++;
    end

endmodule

// ==== hdl/sprUnit.sv ====
/*
 * SPR unit top
 * decode, LR/CTR, SPRGs, exception registers and the mfspr read mux
 */
`timescale 1ns/1ps
`include "spr_macros.svh"

module sprUnit (
  input  logic                       CB,
  input  logic                       rstN,
  input  sprPkg::exeOpT              exeOp,
  input  sprPkg::exceptT             exception,
  input  logic                       sprHold,
  input  logic [`SPR_ADDR_WIDTH-1:0] refetchAddr,
  input  logic [`SPR_WIDTH-1:0]      crIn,
  output sprPkg::sprWordU            readData,
  output logic [`SPR_WIDTH-1:0]      link,
  output logic [`SPR_WIDTH-1:0]      ctr,
  output logic                       ctrEq1,
  output logic                       ctrEq2,
  output logic [`EVPR_WIDTH-1:0]     evpr,
  output logic [`SPR_ADDR_WIDTH-1:0] returnAddr,
  output logic                       exeMtLr,
  output logic                       exeMtCtr
);

  sprPkg::sprWrEnT                        wrEn;
  sprPkg::sprRdSrcE                       rdSrc;
  logic [`SPRG_COUNT-1:0][`SPR_WIDTH-1:0] sprg;
  logic [`SPR_ADDR_WIDTH-1:0]             srr0;
  logic [`SPR_ADDR_WIDTH-1:0]             srr2;
  logic                                   srr2Read;

  // srr2 access in exe steers the return address
  assign srr2Read = (rdSrc == sprPkg::rdSrr2);

  sprDecode sprDecode_i (
    .exeOp(exeOp), .exception(exception), .sprHold(sprHold),
    .wrEn(wrEn), .rdSrc(rdSrc), .exeMtLr(exeMtLr), .exeMtCtr(exeMtCtr)
  );

  branchRegs branchRegs_i (
    .CB(CB), .rstN(rstN), .wrEn(wrEn), .exeOp(exeOp),
    .link(link), .ctr(ctr), .ctrEq1(ctrEq1), .ctrEq2(ctrEq2)
  );

  generalSprs generalSprs_i (
    .CB(CB), .rstN(rstN), .wrEn(wrEn), .writeData(exeOp.data), .sprg(sprg)
  );

  exceptionRegs exceptionRegs_i (
    .CB(CB), .rstN(rstN), .wrEn(wrEn), .writeData(exeOp.data),
    .refetchAddr(refetchAddr), .wbRfci(exception.wbRfci), .srr2Read(srr2Read),
    .evpr(evpr), .srr0(srr0), .srr2(srr2), .returnAddr(returnAddr)
  );

  // combinational, same cycle as exeOp
  sprReadMux sprReadMux_i (
    .rdSrc(rdSrc), .writeData(exeOp.data), .crIn(crIn), .link(link),
    .ctr(ctr), .evpr(evpr), .sprg(sprg), .srr0(srr0), .srr2(srr2),
    .readData(readData)
  );

endmodule

// ==== hdl/sprReadMux.sv ====
/*
 * mfspr read mux
 * selects the addressed SPR, or passes the write bus through
 * when no mfspr is active
 */
`timescale 1ns/1ps
`include "spr_macros.svh"

module sprReadMux (
  input  sprPkg::sprRdSrcE                        rdSrc,
  input  sprPkg::sprWordU                         writeData,
  input  logic [`SPR_WIDTH-1:0]                   crIn,
  input  logic [`SPR_WIDTH-1:0]                   link,
  input  logic [`SPR_WIDTH-1:0]                   ctr,
  input  logic [`EVPR_WIDTH-1:0]                  evpr,
  input  logic [`SPRG_COUNT-1:0][`SPR_WIDTH-1:0]  sprg,
  input  logic [`SPR_ADDR_WIDTH-1:0]              srr0,
  input  logic [`SPR_ADDR_WIDTH-1:0]              srr2,
  output sprPkg::sprWordU                         readData
);

  always_comb begin
    readData = writeData;
    // sprg codes carry the index in the low bits
    if (rdSrc[3]) begin
      readData.data = sprg[rdSrc[2:0]];
    end else begin
      case (rdSrc)
        sprPkg::rdCr:   readData.data = crIn;
        sprPkg::rdLr:   readData.data = link;
        sprPkg::rdCtr:  readData.data = ctr;
        // prefix in the top half
        sprPkg::rdEvpr: readData.data = {evpr, {(`SPR_WIDTH-`EVPR_WIDTH){1'b0}}};
        sprPkg::rdSrr0: begin
          readData.addr.word = srr0;
          readData.addr.pad  = '0;
        end
        sprPkg::rdSrr2: begin
          readData.addr.word = srr2;
          readData.addr.pad  = '0;
        end
        // bypass, write bus goes straight through
        default:        readData = writeData;
      endcase
    end
  end

endmodule

// ==== hdl/exceptionRegs.sv ====
/*
 * exception registers
 * EVPR, SRR0 and SRR2 with interrupt swap loading, plus the
 * return address select for rfi/rfci
 */
`timescale 1ns/1ps
`include "spr_macros.svh"

module exceptionRegs (
  input  logic                       CB,
  input  logic                       rstN,
  input  sprPkg::sprWrEnT            wrEn,
  input  sprPkg::sprWordU            writeData,
  input  logic [`SPR_ADDR_WIDTH-1:0] refetchAddr,
  input  logic                       wbRfci,
  input  logic                       srr2Read,
  output logic [`EVPR_WIDTH-1:0]     evpr,
  output logic [`SPR_ADDR_WIDTH-1:0] srr0,
  output logic [`SPR_ADDR_WIDTH-1:0] srr2,
  output logic [`SPR_ADDR_WIDTH-1:0] returnAddr
);

  logic [1:0]                       srrMt;
  logic [1:0][`SPR_ADDR_WIDTH-1:0]  srrQ;

  // evpr keeps the upper half of the word
  always_ff @(posedge CB) begin
    if (!rstN) begin
      evpr <= '0;
    end else if (wrEn.evpr) begin
      evpr <= writeData.data[`SPR_WIDTH-1 -: `EVPR_WIDTH];
    end
  end

  //********************************************************************
  // srr0 / srr2
  //********************************************************************

  assign srrMt = {wrEn.srr2, wrEn.srr0};

  // swap takes priority, it is never held
  for (genvar i = 0; i < 2; i++) begin : gSrr
    always_ff @(posedge CB) begin
      if (!rstN) begin
        srrQ[i] <= '0;
      end else if (wrEn.srrSwap[i]) begin
        srrQ[i] <= refetchAddr;
      end else if (srrMt[i]) begin
        srrQ[i] <= writeData.addr.word;
      end
    end
  end

  assign srr0 = srrQ[0];
  assign srr2 = srrQ[1];

  // rfci or an srr2 access in exe picks srr2
  // exe is empty while rfi/rfci sits in wb
  assign returnAddr = (wbRfci | srr2Read) ? srr2 : srr0;

endmodule

// ==== hdl/generalSprs.sv ====
/*
 * general SPRGs
 * eight 32-bit software registers, each with its own write enable
 */
`timescale 1ns/1ps
`include "spr_macros.svh"

module generalSprs (
  input  logic                                    CB,
  input  logic                                    rstN,
  input  sprPkg::sprWrEnT                         wrEn,
  input  sprPkg::sprWordU                         writeData,
  output logic [`SPRG_COUNT-1:0][`SPR_WIDTH-1:0]  sprg
);

  //********************************************************************
  // register array
  //********************************************************************

  // one flop bank per sprg
  for (genvar i = 0; i < `SPRG_COUNT; i++) begin : gSprg
    always_ff @(posedge CB) begin
      if (!rstN) begin
        sprg[i] <= '0;
      end else if (wrEn.sprg[i]) begin
        // full word, no address view
        sprg[i] <= writeData.data;
      end
    end
  end

endmodule

// ==== hdl/branchRegs.sv ====
/*
 * link and count registers
 * branch-and-link increment, bc decrement and the registered
 * next-ctr-equals-1/2 flags
 */
`timescale 1ns/1ps
`include "spr_macros.svh"

module branchRegs (
  input  logic                      CB,
  input  logic                      rstN,
  input  sprPkg::sprWrEnT           wrEn,
  input  sprPkg::exeOpT             exeOp,
  output logic [`SPR_WIDTH-1:0]     link,
  output logic [`SPR_WIDTH-1:0]     ctr,
  output logic                      ctrEq1,
  output logic                      ctrEq2
);

  logic [`SPR_ADDR_WIDTH-1:0] linkInc;
  logic [`SPR_WIDTH-1:0]      linkNext;
  logic [`SPR_WIDTH-1:0]      ctrNext;
  logic                       ctrUpd;

  // return address, next word after the branch
  assign linkInc = exeOp.data.addr.word + 1'b1;

  // link source, pad bits forced to zero on branch-and-link
  assign linkNext = exeOp.branchAndLink ? {linkInc, 2'b00} : exeOp.data.data;

  // decrement wins over a same-cycle mtspr
  assign ctrNext = wrEn.ctrDecr ? ctr - 1'b1 : exeOp.data.data;
  assign ctrUpd  = wrEn.ctr | wrEn.ctrDecr;

  //********************************************************************
  // lr
  //********************************************************************

  always_ff @(posedge CB) begin
    if (!rstN) begin
      link <= '0;
    end else if (wrEn.lr) begin
      link <= linkNext;
    end
  end

  //********************************************************************
  // ctr and compare flags
  //********************************************************************

  // flags look at the value being loaded, so they line up with ctr
  always_ff @(posedge CB) begin
    if (!rstN) begin
      ctr    <= `CTR_RESET;
      ctrEq1 <= 1'b0;
      ctrEq2 <= 1'b0;
    end else if (ctrUpd) begin
      ctr    <= ctrNext;
      ctrEq1 <= (ctrNext == `SPR_WIDTH'd1);
      ctrEq2 <= (ctrNext == `SPR_WIDTH'd2);
    end
  end

endmodule

// ==== hdl/sprDecode.sv ====
/*
 * SPR number decode
 * turns the execute-stage operation into register write enables,
 * swap enables and the mfspr read source
 */
`timescale 1ns/1ps
`include "spr_macros.svh"

module sprDecode (
  input  sprPkg::exeOpT    exeOp,
  input  sprPkg::exceptT   exception,
  input  logic             sprHold,
  output sprPkg::sprWrEnT  wrEn,
  output sprPkg::sprRdSrcE rdSrc,
  output logic             exeMtLr,
  output logic             exeMtCtr
);

  localparam int SprgIdxW = $clog2(`SPRG_COUNT);

  logic [`SPRN_WIDTH-1:0] sprn;
  logic                   crSel, lrSel, ctrSel, evprSel, srr0Sel, srr2Sel;
  logic                   sprgSel, sprgRoSel;
  logic                   mtOk;
  logic [SprgIdxW-1:0]    rdIdx;

  //********************************************************************
  // number decode
  //********************************************************************

  // sprf carries the two 5-bit halves in swapped order
  assign sprn = {exeOp.sprf[4:0], exeOp.sprf[9:5]};

  assign crSel   = (sprn == `SPRN_CR);
  assign lrSel   = (sprn == `SPRN_LR);
  assign ctrSel  = (sprn == `SPRN_CTR);
  assign evprSel = (sprn == `SPRN_EVPR);
  assign srr0Sel = (sprn == `SPRN_SRR0);
  assign srr2Sel = (sprn == `SPRN_SRR2);

  // full sprg window, readable and writable
  assign sprgSel = (sprn >= `SPRN_SPRG_BASE) &&
                   (sprn < `SPRN_SPRG_BASE + `SPRG_COUNT);
  // upper half only, read-only
  assign sprgRoSel = (sprn >= `SPRN_SPRG_RO_BASE) &&
                     (sprn < `SPRN_SPRG_RO_BASE + `SPRG_COUNT / 2);

  // alias window maps onto sprg4-7
  assign rdIdx = sprgSel ? sprn[SprgIdxW-1:0] : {1'b1, sprn[SprgIdxW-2:0]};

  //********************************************************************
  // write enables
  //********************************************************************

  // mtspr only lands when not held
  assign mtOk = exeOp.mtspr & ~sprHold;

  always_comb begin
    wrEn = '0;
    // branch-and-link also held off by sprHold
    wrEn.lr      = ~sprHold & (exeOp.branchAndLink | (exeOp.mtspr & lrSel));
    wrEn.ctr     = mtOk & ctrSel;
    wrEn.ctrDecr = ~sprHold & exeOp.bcDecr;
    wrEn.evpr    = mtOk & evprSel;
    // ro aliases and cr never get an enable
    if (mtOk && sprgSel) begin
      wrEn.sprg[sprn[SprgIdxW-1:0]] = 1'b1;
    end
    wrEn.srr0 = mtOk & srr0Sel;
    wrEn.srr2 = mtOk & srr2Sel;
    // interrupt swaps ignore hold
    wrEn.srrSwap[0] = exception.swap01 & exception.swapEnable;
    wrEn.srrSwap[1] = exception.swap23 & exception.swapEnable;
  end

  //********************************************************************
  // read source
  //********************************************************************

  always_comb begin
    rdSrc = sprPkg::rdBypass;
    if (exeOp.mfspr) begin
      if (crSel) begin
        rdSrc = sprPkg::rdCr;
      end else if (lrSel) begin
        rdSrc = sprPkg::rdLr;
      end else if (ctrSel) begin
        rdSrc = sprPkg::rdCtr;
      end else if (evprSel) begin
        rdSrc = sprPkg::rdEvpr;
      end else if (srr0Sel) begin
        rdSrc = sprPkg::rdSrr0;
      end else if (srr2Sel) begin
        rdSrc = sprPkg::rdSrr2;
      end else if (sprgSel || sprgRoSel) begin
        // sprg codes are 1 followed by the index
        rdSrc = sprPkg::sprRdSrcE'({1'b1, rdIdx});
      end
    end
  end

  // mtspr to lr/ctr, seen before hold
  assign exeMtLr  = exeOp.mtspr & lrSel;
  assign exeMtCtr = exeOp.mtspr & ctrSel;

endmodule

// ==== hdl/sprPkg.sv ====
/*
 * SPR block types
 * execute-stage operation, exception controls, write enables,
 * read source select and the two views of an SPR word
 */
`include "spr_macros.svh"

package sprPkg;

  // one spr word, seen as data or as word address plus pad
  typedef union packed {
    logic [`SPR_WIDTH-1:0] data;
    struct packed {
      logic [`SPR_ADDR_WIDTH-1:0]          word;
      logic [`SPR_WIDTH-`SPR_ADDR_WIDTH-1:0] pad;
    } addr;
  } sprWordU;

  // execute-stage operation
  typedef struct packed {
    logic                  mtspr;
    logic                  mfspr;
    // instruction field, halves still swapped
    logic [`SPRN_WIDTH-1:0] sprf;
    logic                  branchAndLink;
    // bc that decrements ctr
    logic                  bcDecr;
    sprWordU               data;
  } exeOpT;

  // interrupt controls from the vector logic
  typedef struct packed {
    logic swap01;
    logic swap23;
    logic swapEnable;
    logic wbRfci;
  } exceptT;

  // register write enables, hold already applied where it counts
  typedef struct packed {
    logic                   lr;
    logic                   ctr;
    logic                   ctrDecr;
    logic                   evpr;
    logic [`SPRG_COUNT-1:0] sprg;
    logic                   srr0;
    logic                   srr2;
    // bit 0 srr0, bit 1 srr2
    logic [1:0]             srrSwap;
  } sprWrEnT;

  // read source, msb set means sprg with index in the low bits
  typedef enum logic [3:0] {
    rdBypass = 4'd0,
    rdCr     = 4'd1,
    rdLr     = 4'd2,
    rdCtr    = 4'd3,
    rdEvpr   = 4'd4,
    rdSprg0  = 4'd8,
    rdSprg1  = 4'd9,
    rdSprg2  = 4'd10,
    rdSprg3  = 4'd11,
    rdSprg4  = 4'd12,
    rdSprg5  = 4'd13,
    rdSprg6  = 4'd14,
    rdSprg7  = 4'd15,
    rdSrr0   = 4'd5,
    rdSrr2   = 4'd6
  } sprRdSrcE;

endpackage

// ==== hdl/spr_macros.svh ====
/*
 * SPR block constants
 * data and address widths, SPR numbers and reset values
 */
`ifndef SPR_MACROS_SVH
`define SPR_MACROS_SVH

// widths
`define SPR_WIDTH         32
`define SPR_ADDR_WIDTH    30
`define SPRN_WIDTH        10
`define EVPR_WIDTH        16
`define SPRG_COUNT        8

// ctr comes out of reset all ones
`define CTR_RESET         32'hFFFF_FFFF

// spr numbers, after the sprf halves swap
`define SPRN_CR           10'h000
`define SPRN_LR           10'h008
`define SPRN_CTR          10'h009
`define SPRN_SRR0         10'h01A
`define SPRN_SRR2         10'h3DE
`define SPRN_EVPR         10'h3D6
`define SPRN_SPRG_BASE    10'h110
// read-only alias window of sprg4-7
`define SPRN_SPRG_RO_BASE 10'h104

`endif
